// ==== list.f ====
cache_pkg.sv
cache_way.sv
cache_lru.sv
cache_ctrl.sv
cache_top.sv
tb_mem_model.sv
tb_cache.sv

// ==== Makefile ====
SRCS := cache_pkg.sv cache_way.sv cache_lru.sv cache_ctrl.sv cache_top.sv \
        tb_mem_model.sv tb_cache.sv

obj_dir/Vtb_cache: list.f $(SRCS)
	verilator --binary --top-module tb_cache -f list.f -o Vtb_cache

run: obj_dir/Vtb_cache
	./obj_dir/Vtb_cache > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== tb_cache.sv ====
/* testbench for the four-way cache: directed and random processor traffic
   checked against a shadow memory and a tag, dirty and LRU model */
`timescale 1ns/1ps
`default_nettype none

module tb_cache;
    import cache_pkg::*;

    localparam int NUM_RANDOM   = 400;
    localparam int NUM_DIRECTED = 28;
    localparam int CLK_PERIOD   = 40;
    localparam int SEED         = 65;
    localparam int WATCHDOG_NS  = (NUM_RANDOM + NUM_DIRECTED) * 40 * CLK_PERIOD;

    logic       clk;
    logic       rst;
    p_addr_t    p_addr;
    be_t        p_byte_en;
    word_t      p_writedata;
    logic       p_read;
    logic       p_write;
    word_t      p_readdata;
    logic       p_readdata_valid;
    logic       p_waitrequest;
    m_addr_t    m_addr;
    be_t        m_byte_en;
    line_t      m_writedata;
    logic       m_read;
    logic       m_write;
    line_t      m_readdata;
    logic       m_readdata_valid;
    logic       m_waitrequest;

    word_t      shadow [p_addr_t];             // processor view of memory
    logic       mdl_valid [NUM_SETS][NUM_WAYS];
    logic       mdl_dirty [NUM_SETS][NUM_WAYS];
    tag_t       mdl_tag   [NUM_SETS][NUM_WAYS];
    int         lru_order [NUM_SETS][NUM_WAYS]; // [0] is least recent
    int unsigned seed_val;

    cache_top dut (
        .clk                (clk),
        .rst                (rst),
        .i_p_addr           (p_addr),
        .i_p_byte_en        (p_byte_en),
        .i_p_writedata      (p_writedata),
        .i_p_read           (p_read),
        .i_p_write          (p_write),
        .o_p_readdata       (p_readdata),
        .o_p_readdata_valid (p_readdata_valid),
        .o_p_waitrequest    (p_waitrequest),
        .o_m_addr           (m_addr),
        .o_m_byte_en        (m_byte_en),
        .o_m_writedata      (m_writedata),
        .o_m_read           (m_read),
        .o_m_write          (m_write),
        .i_m_readdata       (m_readdata),
        .i_m_readdata_valid (m_readdata_valid),
        .i_m_waitrequest    (m_waitrequest)
    );

    tb_mem_model u_mem (
        .clk           (clk),
        .rst           (rst),
        .i_addr        (m_addr),
        .i_wdata       (m_writedata),
        .i_read        (m_read),
        .i_write       (m_write),
        .o_rdata       (m_readdata),
        .o_rdata_valid (m_readdata_valid),
        .o_waitrequest (m_waitrequest)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (expected == actual) else
            report_failure($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    endtask

    function automatic word_t shadow_word(input p_addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return {a, 7'h2b};   // same start content as the memory model
    endfunction

    function automatic line_t shadow_line(input line_addr_t l);
        line_t v;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            v[w*WORD_W +: WORD_W] = shadow_word({l, 2'(w)});
        end
        return v;
    endfunction

    task automatic touch_lru(input index_t set, input int way);
        int pos;
        pos = 0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (lru_order[set][i] == way) begin
                pos = i;
            end
        end
        for (int i = pos; i < NUM_WAYS - 1; i++) begin
            lru_order[set][i] = lru_order[set][i+1];
        end
        lru_order[set][NUM_WAYS-1] = way;
    endtask

    // one request from issue to completion, with prediction and model update
    task automatic run_request(input logic is_write, input p_addr_t addr, input be_t be,
                               input word_t data, input string name);
        line_addr_t line;
        index_t     set;
        tag_t       tag;
        int         hit_way;
        int         victim;
        logic       need_wb;
        line_addr_t wb_line;
        line_t      wb_data;
        word_t      exp_word;
        word_t      merged;
        int         cyc;
        logic       done;
        logic       wb_seen;
        logic       fill_seen;
        line    = addr[$bits(p_addr_t)-1:2];
        set     = line[INDEX_W-1:0];
        tag     = line[LINE_ADDR_W-1:INDEX_W];
        hit_way = -1;
        victim  = -1;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (mdl_valid[set][w] && mdl_tag[set][w] == tag) begin
                hit_way = w;
            end
            if (!mdl_valid[set][w]) begin
                victim = w;
            end
        end
        if (victim < 0) begin
            victim = lru_order[set][0];
        end
        need_wb   = (hit_way < 0) && mdl_valid[set][victim] && mdl_dirty[set][victim];
        wb_line   = {mdl_tag[set][victim], set};
        wb_data   = shadow_line(wb_line);
        exp_word  = shadow_word(addr);
        wb_seen   = 1'b0;
        fill_seen = 1'b0;
        done      = 1'b0;
        cyc       = 0;

        @(posedge clk);
        p_addr      <= addr;
        p_byte_en   <= be;
        p_writedata <= data;
        p_read      <= !is_write;
        p_write     <= is_write;
        @(posedge clk);   // accepted here, the DUT is idle
        p_read      <= 1'b0;
        p_write     <= 1'b0;

        while (!done) begin
            @(negedge clk);
            if ((m_write || m_read) && !m_waitrequest) begin
                check_equal({name, " byte enables"}, 128'hf, 128'(m_byte_en));
            end
            if (m_write && !m_waitrequest) begin
                assert (need_wb && !fill_seen && !wb_seen) else
                    report_failure({name, ": memory write without a dirty victim"});
                check_equal({name, " wb addr"}, 128'({wb_line, 3'b000}), 128'(m_addr));
                check_equal({name, " wb data"}, wb_data, m_writedata);
                wb_seen = 1'b1;
            end
            if (m_read && !m_waitrequest) begin
                assert (hit_way < 0 && !fill_seen) else
                    report_failure({name, ": unexpected memory read"});
                assert (!need_wb || wb_seen) else
                    report_failure({name, ": fill read came before the write-back"});
                check_equal({name, " fill addr"}, 128'({line, 3'b000}), 128'(m_addr));
                fill_seen = 1'b1;
            end
            if (!is_write && p_readdata_valid) begin
                check_equal({name, " read data"}, 128'(exp_word), 128'(p_readdata));
                if (hit_way >= 0) begin
                    check_equal({name, " read hit cycles"}, 128'(2), 128'(cyc));
                end
                done = 1'b1;
            end else if (is_write && !p_waitrequest) begin
                if (hit_way >= 0) begin
                    check_equal({name, " write hit cycles"}, 128'(2), 128'(cyc));
                end
                done = 1'b1;
            end
            cyc++;
        end
        assert ((hit_way >= 0) != fill_seen) else
            report_failure({name, ": fill read does not match the hit prediction"});
        assert (need_wb == wb_seen) else
            report_failure({name, ": dirty victim was not written back"});

        if (is_write) begin
            merged = shadow_word(addr);
            for (int b = 0; b < $bits(be_t); b++) begin
                if (be[b]) begin
                    merged[b*8 +: 8] = data[b*8 +: 8];
                end
            end
            shadow[addr] = merged;
        end
        if (hit_way >= 0) begin
            mdl_dirty[set][hit_way] = mdl_dirty[set][hit_way] || is_write;
            touch_lru(set, hit_way);
        end else begin
            mdl_valid[set][victim] = 1'b1;
            mdl_tag[set][victim]   = tag;
            mdl_dirty[set][victim] = is_write;
            touch_lru(set, victim);
        end
    endtask

    // 8 sets and 6 tags per set, so sets overflow and evict
    function automatic p_addr_t random_addr();
        index_t set;
        tag_t   tag;
        set = index_t'($urandom_range(7, 0) * 5);
        tag = tag_t'($urandom_range(5, 0) + 32'h00a0);
        return {tag, set, 2'($urandom_range(3, 0))};
    endfunction

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the cache did not finish the requests in time");
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

    initial begin
        rst         = 1'b1;
        p_addr      = '0;
        p_byte_en   = '0;
        p_writedata = '0;
        p_read      = 1'b0;
        p_write     = 1'b0;
        seed_val    = $urandom(SEED);
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                mdl_valid[s][w] = 1'b0;
                mdl_dirty[s][w] = 1'b0;
                mdl_tag[s][w]   = '0;
                lru_order[s][w] = w;
            end
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!p_waitrequest && !p_readdata_valid && !m_read && !m_write) else
            report_failure("outputs not idle after reset");

        // cold miss, read hit, write hit, read back
        run_request(1'b0, {17'h00010, 6'd3, 2'd1}, 4'hf, 32'h0, "cold read");
        run_request(1'b0, {17'h00010, 6'd3, 2'd2}, 4'hf, 32'h0, "read hit");
        run_request(1'b1, {17'h00010, 6'd3, 2'd2}, 4'h5, 32'hcafe_f00d, "write hit");
        run_request(1'b0, {17'h00010, 6'd3, 2'd2}, 4'hf, 32'h0, "read after write");
        // dirty lines through one set, then read them back
        for (int t = 0; t < 6; t++) begin
            run_request(1'b1, {17'(32'h20 + t), 6'd9, 2'(t)}, 4'hf, 32'h1000 + t, "dirty fill");
        end
        for (int t = 0; t < 6; t++) begin
            run_request(1'b0, {17'(32'h20 + t), 6'd9, 2'(t)}, 4'hf, 32'h0, "dirty readback");
        end
        // clean lines evicted without a write-back
        for (int t = 0; t < 12; t++) begin
            run_request(1'b0, {17'(32'h40 + t % 6), 6'd17, 2'd0}, 4'hf, 32'h0, "clean evict");
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            run_request(1'($urandom_range(1, 0)), random_addr(), 4'($urandom_range(15, 0)),
                        $urandom, "random");
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
/* behavioural line-wide memory for the cache testbench
   random waitrequest, read data returned 1 to 4 cycles after a read is accepted */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  wire                     clk,
    input  wire                     rst,
    input  wire cache_pkg::m_addr_t i_addr,
    input  wire cache_pkg::line_t   i_wdata,
    input  wire                     i_read,
    input  wire                     i_write,
    output cache_pkg::line_t        o_rdata,
    output logic                    o_rdata_valid,
    output logic                    o_waitrequest
);
    import cache_pkg::*;

    line_t      mem [line_addr_t];   // only lines that were written back
    logic       pending;
    int         delay;
    line_addr_t rd_line;

    // untouched lines hold their own word address in the top bits
    function automatic line_t read_line(input line_addr_t l);
        line_t v;
        if (mem.exists(l)) begin
            return mem[l];
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            v[w*WORD_W +: WORD_W] = {l, 2'(w), 7'h2b};
        end
        return v;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            o_waitrequest <= 1'b1;
            o_rdata_valid <= 1'b0;
            o_rdata       <= '0;
            pending = 1'b0;
            delay   = 0;
        end else begin
            o_rdata_valid <= 1'b0;
            if (pending) begin
                if (delay == 0) begin
                    o_rdata       <= read_line(rd_line);
                    o_rdata_valid <= 1'b1;
                    pending = 1'b0;
                end else begin
                    delay = delay - 1;
                end
            end
            if (i_write && !o_waitrequest) begin
                mem[i_addr[$bits(m_addr_t)-1:3]] = i_wdata;
            end
            if (i_read && !o_waitrequest) begin
                rd_line = i_addr[$bits(m_addr_t)-1:3];
                delay   = int'($urandom_range(3, 0));
                pending = 1'b1;
            end
            o_waitrequest <= ($urandom_range(2, 0) == 0);   // busy about a third of the time
        end
    end

endmodule

`default_nettype wire

// ==== cache_top.sv ====
/* four-way write-back cache between a processor port and a line-wide memory port
   ways, LRU store and controller are wired here */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire cache_pkg::p_addr_t  i_p_addr,
    input  wire cache_pkg::be_t      i_p_byte_en,
    input  wire cache_pkg::word_t    i_p_writedata,
    input  wire                      i_p_read,
    input  wire                      i_p_write,
    output cache_pkg::word_t         o_p_readdata,
    output logic                     o_p_readdata_valid,
    output logic                     o_p_waitrequest,
    output cache_pkg::m_addr_t       o_m_addr,
    output cache_pkg::be_t           o_m_byte_en,
    output cache_pkg::line_t         o_m_writedata,
    output logic                     o_m_read,
    output logic                     o_m_write,
    input  wire cache_pkg::line_t    i_m_readdata,
    input  wire                      i_m_readdata_valid,
    input  wire                      i_m_waitrequest
);
    import cache_pkg::*;

    index_t                      way_index;
    tag_t                        way_tag;
    line_t                       way_wdata;
    be_t                         way_byte_en;
    logic [WORDS_PER_LINE-1:0]   way_word_en;
    logic [NUM_WAYS-1:0]         way_write;
    logic                        way_fill_clean;
    line_t [NUM_WAYS-1:0]        way_rdata;
    logic [NUM_WAYS-1:0]         way_hit;
    logic [NUM_WAYS-1:0]         way_valid;
    logic [NUM_WAYS-1:0]         way_dirty;
    line_addr_t [NUM_WAYS-1:0]   way_victim_addr;
    way_idx_t                    lru_way;
    way_idx_t                    lru_victim;
    logic                        lru_update;

    assign o_m_byte_en = '1;   // memory always moves full lines

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        cache_way u_way (
            .clk           (clk),
            .rst           (rst),
            .i_index       (way_index),
            .i_tag         (way_tag),
            .i_wdata       (way_wdata),
            .i_byte_en     (way_byte_en),
            .i_word_en     (way_word_en),
            .i_write       (way_write[g]),
            .i_fill_clean  (way_fill_clean),
            .o_rdata       (way_rdata[g]),
            .o_hit         (way_hit[g]),
            .o_valid       (way_valid[g]),
            .o_dirty       (way_dirty[g]),
            .o_victim_addr (way_victim_addr[g])
        );
    end

    cache_lru u_lru (
        .clk         (clk),
        .rst         (rst),
        .i_index     (way_index),
        .i_touch_way (lru_way),
        .i_update    (lru_update),
        .o_victim    (lru_victim)
    );

    cache_ctrl u_ctrl (
        .clk                (clk),
        .rst                (rst),
        .i_p_addr           (i_p_addr),
        .i_p_byte_en        (i_p_byte_en),
        .i_p_writedata      (i_p_writedata),
        .i_p_read           (i_p_read),
        .i_p_write          (i_p_write),
        .o_p_readdata       (o_p_readdata),
        .o_p_readdata_valid (o_p_readdata_valid),
        .o_p_waitrequest    (o_p_waitrequest),
        .o_m_addr           (o_m_addr),
        .o_m_writedata      (o_m_writedata),
        .o_m_read           (o_m_read),
        .o_m_write          (o_m_write),
        .i_m_readdata       (i_m_readdata),
        .i_m_readdata_valid (i_m_readdata_valid),
        .i_m_waitrequest    (i_m_waitrequest),
        .o_index            (way_index),
        .o_tag              (way_tag),
        .o_wdata            (way_wdata),
        .o_byte_en          (way_byte_en),
        .o_word_en          (way_word_en),
        .o_way_write        (way_write),
        .o_fill_clean       (way_fill_clean),
        .i_way_rdata        (way_rdata),
        .i_hit              (way_hit),
        .i_valid            (way_valid),
        .i_dirty            (way_dirty),
        .i_victim_addr      (way_victim_addr),
        .o_lru_way          (lru_way),
        .o_lru_update       (lru_update),
        .i_lru_victim       (lru_victim)
    );

endmodule

`default_nettype wire

// ==== cache_ctrl.sv ====
/* cache controller: captures a processor request, sequences hit, write-back and fill,
   drives the memory port and returns the read word */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  wire                          clk,
    input  wire                          rst,
    // processor side
    input  wire cache_pkg::p_addr_t      i_p_addr,
    input  wire cache_pkg::be_t          i_p_byte_en,
    input  wire cache_pkg::word_t        i_p_writedata,
    input  wire                          i_p_read,
    input  wire                          i_p_write,
    output cache_pkg::word_t             o_p_readdata,
    output logic                         o_p_readdata_valid,
    output logic                         o_p_waitrequest,
    // memory side
    output cache_pkg::m_addr_t           o_m_addr,
    output cache_pkg::line_t             o_m_writedata,
    output logic                         o_m_read,
    output logic                         o_m_write,
    input  wire cache_pkg::line_t        i_m_readdata,
    input  wire                          i_m_readdata_valid,
    input  wire                          i_m_waitrequest,
    // to the ways
    output cache_pkg::index_t            o_index,
    output cache_pkg::tag_t              o_tag,
    output cache_pkg::line_t             o_wdata,
    output cache_pkg::be_t               o_byte_en,
    output logic [cache_pkg::WORDS_PER_LINE-1:0] o_word_en,
    output logic [cache_pkg::NUM_WAYS-1:0]       o_way_write,
    output logic                         o_fill_clean,
    // from the ways
    input  wire cache_pkg::line_t [cache_pkg::NUM_WAYS-1:0]      i_way_rdata,
    input  wire [cache_pkg::NUM_WAYS-1:0]                        i_hit,
    input  wire [cache_pkg::NUM_WAYS-1:0]                        i_valid,
    input  wire [cache_pkg::NUM_WAYS-1:0]                        i_dirty,
    input  wire cache_pkg::line_addr_t [cache_pkg::NUM_WAYS-1:0] i_victim_addr,
    // LRU store
    output cache_pkg::way_idx_t          o_lru_way,
    output logic                         o_lru_update,
    input  wire cache_pkg::way_idx_t     i_lru_victim
);
    import cache_pkg::*;

    ctrl_state_t                state;
    p_addr_t                    addr_buf;    // captured request
    word_t                      wdata_buf;
    be_t                        be_buf;
    logic                       req_write;
    way_idx_t                   fill_way;    // victim or free way of a miss
    p_addr_t                    lookup_addr;
    line_addr_t                 lookup_line;
    line_addr_t                 req_line;
    logic [OFFSET_W-1:0]        word_sel;
    logic [WORDS_PER_LINE-1:0]  word_onehot;
    logic [NUM_WAYS-1:0]        fill_onehot;
    way_idx_t                   hit_way;
    way_idx_t                   free_way;
    line_t                      hit_line;

    // ways and LRU read synchronously, so IDLE looks up the incoming address
    assign lookup_addr = (state == IDLE) ? i_p_addr : addr_buf;
    assign lookup_line = lookup_addr[$bits(p_addr_t)-1:OFFSET_W];
    assign o_index     = lookup_line[INDEX_W-1:0];
    assign o_tag       = lookup_line[LINE_ADDR_W-1:INDEX_W];

    assign req_line    = addr_buf[$bits(p_addr_t)-1:OFFSET_W];
    assign word_sel    = addr_buf[OFFSET_W-1:0];
    assign word_onehot = {{(WORDS_PER_LINE-1){1'b0}}, 1'b1} << word_sel;
    assign fill_onehot = {{(NUM_WAYS-1){1'b0}}, 1'b1} << fill_way;

    assign o_p_waitrequest = (state != IDLE);

    // lowest hitting way and lowest invalid way
    always_comb begin
        hit_way  = '0;
        free_way = '0;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (i_hit[i]) begin
                hit_way = way_idx_t'(i);
            end
            if (!i_valid[i]) begin
                free_way = way_idx_t'(i);
            end
        end
    end

    assign hit_line = i_way_rdata[hit_way];

    // fill writes the whole returned line, otherwise one word of the request
    assign o_wdata      = (state == FETCH_WAIT) ? i_m_readdata : {WORDS_PER_LINE{wdata_buf}};
    assign o_byte_en    = (state == FETCH_WAIT) ? '1 : be_buf;
    assign o_word_en    = (state == FETCH_WAIT) ? '1 : word_onehot;
    assign o_fill_clean = (state == FETCH_WAIT) && !req_write;

    always_comb begin
        case (state)
            HIT:         o_way_write = req_write ? i_hit : '0;
            FETCH_WAIT:  o_way_write = i_m_readdata_valid ? fill_onehot : '0;
            FETCH_MERGE: o_way_write = fill_onehot;
            default:     o_way_write = '0;
        endcase
    end

    assign o_lru_way    = (state == HIT) ? hit_way : fill_way;
    assign o_lru_update = (state == HIT) || ((state == FETCH_WAIT) && i_m_readdata_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= IDLE;
            o_p_readdata_valid <= 1'b0;
            o_m_read           <= 1'b0;
            o_m_write          <= 1'b0;
            req_write          <= 1'b0;
            fill_way           <= '0;
        end else begin
            o_p_readdata_valid <= 1'b0;   // single-cycle pulse
            case (state)
                IDLE: begin
                    if (i_p_read || i_p_write) begin
                        req_write <= !i_p_read;   // read wins if both
                        state     <= COMP;
                    end
                end
                COMP: begin
                    if (|i_hit) begin
                        state <= HIT;
                    end else begin
                        fill_way <= (&i_valid) ? i_lru_victim : free_way;
                        if ((&i_valid) && i_dirty[i_lru_victim]) begin
                            state <= WB_LOAD;
                        end else begin
                            o_m_read <= 1'b1;
                            state    <= FETCH_REQ;
                        end
                    end
                end
                HIT: begin
                    o_p_readdata_valid <= !req_write;
                    state              <= IDLE;
                end
                WB_LOAD: begin
                    o_m_write <= 1'b1;
                    state     <= WB_REQ;
                end
                WB_REQ: begin
                    if (!i_m_waitrequest) begin
                        o_m_write <= 1'b0;
                        o_m_read  <= 1'b1;
                        state     <= FETCH_REQ;
                    end
                end
                FETCH_REQ: begin
                    if (!i_m_waitrequest) begin
                        o_m_read <= 1'b0;
                        state    <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (i_m_readdata_valid) begin
                        o_p_readdata_valid <= !req_write;
                        state              <= req_write ? FETCH_MERGE : IDLE;
                    end
                end
                FETCH_MERGE: state <= IDLE;
                default:     state <= IDLE;
            endcase
        end
    end

    // request capture, response word and memory payload
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                addr_buf  <= i_p_addr;
                wdata_buf <= i_p_writedata;
                be_buf    <= i_p_byte_en;
            end
            COMP:       o_m_addr <= {req_line, 3'b000};
            HIT:        o_p_readdata <= hit_line[word_sel*WORD_W +: WORD_W];
            WB_LOAD: begin
                o_m_addr      <= {i_victim_addr[fill_way], 3'b000};
                o_m_writedata <= i_way_rdata[fill_way];
            end
            WB_REQ: begin
                if (!i_m_waitrequest) begin
                    o_m_addr <= {req_line, 3'b000};   // fill follows the write-back
                end
            end
            FETCH_WAIT: o_p_readdata <= i_m_readdata[word_sel*WORD_W +: WORD_W];
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== cache_lru.sv ====
/* per-set LRU order for the four ways
   the lowest field names the victim, an update moves the touched way to the top */
`timescale 1ns/1ps
`default_nettype none

module cache_lru (
    input  wire                      clk,
    input  wire                      rst,
    input  wire cache_pkg::index_t   i_index,
    input  wire cache_pkg::way_idx_t i_touch_way,
    input  wire                      i_update,
    output cache_pkg::way_idx_t      o_victim
);
    import cache_pkg::*;

    localparam int FW = $bits(way_idx_t);   // field width

    lru_t lru_mem [NUM_SETS];
    lru_t lru_q;
    lru_t lru_next;
    logic found;

    // fields above the touched way's old slot drop one place
    always_comb begin
        found    = 1'b0;
        lru_next = lru_q;
        for (int i = 0; i < NUM_WAYS - 1; i++) begin
            if (lru_q[FW*i +: FW] == i_touch_way) begin
                found = 1'b1;
            end
            if (found) begin
                lru_next[FW*i +: FW] = lru_q[FW*(i+1) +: FW];
            end
        end
        lru_next[FW*NUM_WAYS-1 -: FW] = i_touch_way;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                lru_mem[s] <= LRU_RESET;
            end
            lru_q <= LRU_RESET;
        end else begin
            if (i_update) begin
                lru_mem[i_index] <= lru_next;
            end
            lru_q <= lru_mem[i_index];
        end
    end

    assign o_victim = lru_q[FW-1:0];

endmodule

`default_nettype wire

// ==== cache_way.sv ====
/* one cache way: line data, tag, valid and dirty per set, all read synchronously
   a write stores the tag and sets dirty unless the fill is marked clean */
`timescale 1ns/1ps
`default_nettype none

module cache_way (
    input  wire                 clk,
    input  wire                 rst,
    input  wire cache_pkg::index_t i_index,
    input  wire cache_pkg::tag_t   i_tag,
    input  wire cache_pkg::line_t  i_wdata,
    input  wire cache_pkg::be_t    i_byte_en,
    input  wire [cache_pkg::WORDS_PER_LINE-1:0] i_word_en,
    input  wire                 i_write,
    input  wire                 i_fill_clean,
    output cache_pkg::line_t    o_rdata,
    output logic                o_hit,
    output logic                o_valid,
    output logic                o_dirty,
    output cache_pkg::line_addr_t o_victim_addr
);
    import cache_pkg::*;

    line_t                 data_mem [NUM_SETS];
    tag_t                  tag_mem  [NUM_SETS];
    logic [NUM_SETS-1:0]   valid_bits;
    logic [NUM_SETS-1:0]   dirty_bits;
    tag_t                  tag_q;

    // byte lanes written only where word and byte enable agree
    always_ff @(posedge clk) begin
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            for (int b = 0; b < $bits(be_t); b++) begin
                if (i_write && i_word_en[w] && i_byte_en[b]) begin
                    data_mem[i_index][w*WORD_W+b*8 +: 8] <= i_wdata[w*WORD_W+b*8 +: 8];
                end
            end
        end
        o_rdata <= data_mem[i_index];
    end

    always_ff @(posedge clk) begin
        if (i_write) begin
            tag_mem[i_index]    <= i_tag;
            dirty_bits[i_index] <= !i_fill_clean;
        end
        tag_q   <= tag_mem[i_index];
        o_dirty <= dirty_bits[i_index];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            o_valid    <= 1'b0;
        end else begin
            if (i_write) begin
                valid_bits[i_index] <= 1'b1;
            end
            o_valid <= valid_bits[i_index];
        end
    end

    assign o_hit         = o_valid && (tag_q == i_tag);
    assign o_victim_addr = {tag_q, i_index};   // line held in this way

endmodule

`default_nettype wire

// ==== cache_pkg.sv ====
/* widths, types and reset constants shared by the cache modules
   every cache module pulls these in with a wildcard import */
`default_nettype none

package cache_pkg;

    localparam int INDEX_W        = 6;      // set index bits
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_WAYS       = 4;
    localparam int WORD_W         = 32;
    localparam int LINE_ADDR_W    = 23;
    localparam int OFFSET_W       = $clog2(WORDS_PER_LINE);
    localparam int TAG_W          = LINE_ADDR_W - INDEX_W;
    localparam int NUM_SETS       = 1 << INDEX_W;

    typedef logic [WORD_W-1:0]                  word_t;
    typedef logic [WORDS_PER_LINE*WORD_W-1:0]   line_t;
    typedef logic [WORD_W/8-1:0]                be_t;
    typedef logic [LINE_ADDR_W+OFFSET_W-1:0]    p_addr_t;   // line address + word
    typedef logic [LINE_ADDR_W+2:0]             m_addr_t;   // line address + 3 zero bits
    typedef logic [LINE_ADDR_W-1:0]             line_addr_t;
    typedef logic [INDEX_W-1:0]                 index_t;
    typedef logic [TAG_W-1:0]                   tag_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]        way_idx_t;

    // four way numbers, lru in [1:0], mru in [7:6]
    typedef logic [NUM_WAYS*$bits(way_idx_t)-1:0] lru_t;

    localparam lru_t LRU_RESET = 8'b11_10_01_00;  // way 0 least recent

    typedef enum logic [2:0] {
        IDLE,
        COMP,
        HIT,
        FETCH_REQ,
        FETCH_WAIT,
        FETCH_MERGE,
        WB_LOAD,
        WB_REQ
    } ctrl_state_t;

endpackage

`default_nettype wire
